// ==== rtl/dmem_macros.svh ====
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// Address and data width
`define DMEM_XLEN 32

// Request buffer entries
`define DMEM_BUF_DEPTH 2

// Number of physical memory attribute regions
`define DMEM_PMA_CNT 4

// Privilege encoding for user mode
`define DMEM_PRV_U 2'b00

// Bus protection code layout
`define DMEM_PROT_W    3
`define DMEM_PROT_DATA 0
`define DMEM_PROT_USER 1
`define DMEM_PROT_PRIV 2

`endif

// ==== rtl/dmem_pkg.sv ====
`include "dmem_macros.svh"

package dmem_pkg;

  // Transfer size, as seen on the CPU and BIU sides
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_e;

  // Data, user and privileged bits
  typedef logic [`DMEM_PROT_W-1:0] prot_t;

  // One queued CPU load or store
  typedef struct packed {
    logic [`DMEM_XLEN-1:0] adr;
    size_e                 size;
    logic                  we;
    logic [`DMEM_XLEN-1:0] d;
    prot_t                 prot;
  } mem_req_t;

  // Attribute region, limit is inclusive
  typedef struct packed {
    logic [`DMEM_XLEN-1:0] base;
    logic [`DMEM_XLEN-1:0] limit;
    logic                  r;
    logic                  w;
    logic                  mis_ok;
  } pma_region_t;

  // Verdict for the head of the buffer
  typedef struct packed {
    logic access_fault;
    logic misaligned_fault;
  } chk_result_t;

  // One-cycle response towards the CPU
  typedef struct packed {
    logic                  ack;
    logic                  err;
    logic                  misaligned;
    logic [`DMEM_XLEN-1:0] q;
  } mem_rsp_t;

endpackage

// ==== rtl/dmem_req_fifo.sv ====
module dmem_req_fifo #(
  parameter type payload_t = dmem_pkg::mem_req_t,
  parameter int  DEPTH     = 2
)
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     valid_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t             mem [DEPTH];
  logic     [PTR_W-1:0] wr_ptr;
  logic     [PTR_W-1:0] rd_ptr;
  logic     [CNT_W-1:0] count;
  logic                 full;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem[wr_ptr] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop_i)
        rd_ptr <= ptr_next(rd_ptr);

      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_o  = mem[rd_ptr];
  assign valid_o = (count != '0);
  assign full    = (count == CNT_W'(DEPTH));

  // A new request into a full buffer is only legal while the head leaves
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i && full |-> pop_i);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> valid_o);

endmodule

// ==== rtl/dmem_align_chk.sv ====
`include "dmem_macros.svh"

module dmem_align_chk
(
  input  logic [`DMEM_XLEN-1:0] adr_i,
  input  dmem_pkg::size_e       size_i,
  output logic                  misaligned_o
);

  import dmem_pkg::*;

  //////////////////////////////////////////////////
  // Natural alignment per access size
  //////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      // Half words need an even address
      SIZE_HALF: misaligned_o = adr_i[0];

      // Words need both low bits clear
      SIZE_WORD: misaligned_o = |adr_i[1:0];

      // Byte accesses are always aligned
      default:   misaligned_o = 1'b0;
    endcase
  end

endmodule

// ==== rtl/dmem_pma_chk.sv ====
`include "dmem_macros.svh"

module dmem_pma_chk
(
  input  dmem_pkg::pma_region_t regions_i [`DMEM_PMA_CNT],
  input  dmem_pkg::mem_req_t    req_i,
  input  logic                  misaligned_i,
  output dmem_pkg::chk_result_t result_o
);

  import dmem_pkg::*;

  logic        hit;
  pma_region_t sel;
  logic        perm_ok;

  //////////////////////////////////////////////////
  // First region in index order that covers the address
  //////////////////////////////////////////////////

  always_comb
  begin
    hit = 1'b0;
    sel = '0;
    for (int i = 0; i < `DMEM_PMA_CNT; i++)
    begin
      if (!hit && req_i.adr >= regions_i[i].base && req_i.adr <= regions_i[i].limit)
      begin
        hit = 1'b1;
        sel = regions_i[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Permission rules
  //////////////////////////////////////////////////

  // Stores need write, loads need read
  assign perm_ok = req_i.we ? sel.w : sel.r;

  // Unmapped or forbidden access takes precedence over misalignment
  assign result_o.access_fault     = !hit || !perm_ok;
  assign result_o.misaligned_fault = hit && perm_ok && misaligned_i && !sel.mis_ok;

endmodule

// ==== rtl/dmem_access_ctrl.sv ====
`include "dmem_macros.svh"

module dmem_access_ctrl
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  dmem_pkg::mem_req_t    head_i,
  input  logic                  head_valid_i,
  input  dmem_pkg::chk_result_t chk_i,
  output logic                  pop_o,
  output dmem_pkg::mem_rsp_t    rsp_o,

  output logic                  biu_stb_o,
  input  logic                  biu_stb_ack_i,
  output logic [`DMEM_XLEN-1:0] biu_adr_o,
  output dmem_pkg::size_e       biu_size_o,
  output logic                  biu_we_o,
  output dmem_pkg::prot_t       biu_prot_o,
  output logic [`DMEM_XLEN-1:0] biu_d_o,
  input  logic [`DMEM_XLEN-1:0] biu_q_i,
  input  logic                  biu_ack_i,
  input  logic                  biu_err_i
);

  import dmem_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_STB, ST_WAIT} state_t;

  state_t                state;
  logic                  rsp_ack;
  logic                  rsp_err;
  logic                  rsp_mis;
  logic [`DMEM_XLEN-1:0] rsp_q;
  logic                  rsp_busy;
  logic                  head_take;
  logic                  start;
  logic                  bus_done;

  //////////////////////////////////////////////////
  // Decisions
  //////////////////////////////////////////////////

  // Head is still in the buffer during its response cycle, so skip it then
  assign rsp_busy  = rsp_ack | rsp_err | rsp_mis;
  assign head_take = (state == ST_IDLE) && head_valid_i && !rsp_busy;
  assign start     = head_take && !chk_i.access_fault && !chk_i.misaligned_fault;

  // Bus may complete in the same cycle as the strobe acknowledge
  assign bus_done = ((state == ST_WAIT) || (state == ST_STB && biu_stb_ack_i)) &&
                    (biu_ack_i || biu_err_i);

  //////////////////////////////////////////////////
  // State machine and response pulses
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state     <= ST_IDLE;
      biu_stb_o <= 1'b0;
      rsp_ack   <= 1'b0;
      rsp_err   <= 1'b0;
      rsp_mis   <= 1'b0;
    end
    else
    begin
      rsp_ack <= bus_done & ~biu_err_i;
      rsp_err <= (head_take & chk_i.access_fault) | (bus_done & biu_err_i);
      rsp_mis <= head_take & ~chk_i.access_fault & chk_i.misaligned_fault;

      if (start)
        biu_stb_o <= 1'b1;
      else if (biu_stb_ack_i)
        biu_stb_o <= 1'b0;

      case (state)
        ST_IDLE: if (start) state <= ST_STB;
        ST_STB:  if (biu_stb_ack_i) state <= ST_WAIT;
        default: state <= state;
      endcase

      if (bus_done)
        state <= ST_IDLE;
    end
  end

  // Transfer fields, captured when the strobe goes up
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      biu_adr_o  <= head_i.adr;
      biu_size_o <= head_i.size;
      biu_we_o   <= head_i.we;
      biu_d_o    <= head_i.d;
      biu_prot_o <= head_i.prot;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (bus_done)
      rsp_q <= biu_q_i;
  end

  assign pop_o = rsp_busy;
  assign rsp_o = '{ack: rsp_ack, err: rsp_err, misaligned: rsp_mis, q: rsp_q};

  // Strobe and its address hold until the BIU takes them
  a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    biu_stb_o && !biu_stb_ack_i |=> biu_stb_o && $stable(biu_adr_o));

  a_rsp_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({rsp_ack, rsp_err, rsp_mis}));

endmodule

// ==== rtl/dmem_top.sv ====
`include "dmem_macros.svh"

module dmem_top
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Configuration
  input  dmem_pkg::pma_region_t pma_regions_i [`DMEM_PMA_CNT],
  input  logic [1:0]            st_prv_i,

  // CPU request
  input  logic                  mem_req_i,
  input  logic [`DMEM_XLEN-1:0] mem_adr_i,
  input  dmem_pkg::size_e       mem_size_i,
  input  logic                  mem_we_i,
  input  logic [`DMEM_XLEN-1:0] mem_d_i,

  // CPU response
  output logic [`DMEM_XLEN-1:0] mem_q_o,
  output logic                  mem_ack_o,
  output logic                  mem_err_o,
  output logic                  mem_misaligned_o,

  // BIU
  output logic                  biu_stb_o,
  input  logic                  biu_stb_ack_i,
  output logic [`DMEM_XLEN-1:0] biu_adr_o,
  output dmem_pkg::size_e       biu_size_o,
  output logic                  biu_we_o,
  output dmem_pkg::prot_t       biu_prot_o,
  output logic [`DMEM_XLEN-1:0] biu_d_o,
  input  logic [`DMEM_XLEN-1:0] biu_q_i,
  input  logic                  biu_ack_i,
  input  logic                  biu_err_i
);

  import dmem_pkg::*;

  prot_t       prot;
  mem_req_t    push_req;
  mem_req_t    head;
  logic        head_valid;
  logic        pop;
  logic        misaligned;
  chk_result_t chk;
  mem_rsp_t    rsp;

  //////////////////////////////////////////////////
  // Protection code and request packing
  //////////////////////////////////////////////////

  always_comb
  begin
    prot = '0;
    prot[`DMEM_PROT_DATA] = 1'b1;
    if (st_prv_i == `DMEM_PRV_U)
      prot[`DMEM_PROT_USER] = 1'b1;
    else
      prot[`DMEM_PROT_PRIV] = 1'b1;
  end

  assign push_req = '{adr: mem_adr_i, size: mem_size_i, we: mem_we_i, d: mem_d_i, prot: prot};

  dmem_req_fifo #(
    .payload_t    ( mem_req_t       ),
    .DEPTH        ( `DMEM_BUF_DEPTH )
  ) u_req_fifo (
    .clk_i        ( clk_i           ),
    .rst_n_i      ( rst_n_i         ),
    .push_i       ( mem_req_i       ),
    .push_data_i  ( push_req        ),
    .pop_i        ( pop             ),
    .head_o       ( head            ),
    .valid_o      ( head_valid      )
  );

  //////////////////////////////////////////////////
  // Checks on the head request
  //////////////////////////////////////////////////

  dmem_align_chk u_align_chk (
    .adr_i        ( head.adr        ),
    .size_i       ( head.size       ),
    .misaligned_o ( misaligned      )
  );

  dmem_pma_chk u_pma_chk (
    .regions_i    ( pma_regions_i   ),
    .req_i        ( head            ),
    .misaligned_i ( misaligned      ),
    .result_o     ( chk             )
  );

  dmem_access_ctrl u_ctrl (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .head_i        ( head          ),
    .head_valid_i  ( head_valid    ),
    .chk_i         ( chk           ),
    .pop_o         ( pop           ),
    .rsp_o         ( rsp           ),
    .biu_stb_o     ( biu_stb_o     ),
    .biu_stb_ack_i ( biu_stb_ack_i ),
    .biu_adr_o     ( biu_adr_o     ),
    .biu_size_o    ( biu_size_o    ),
    .biu_we_o      ( biu_we_o      ),
    .biu_prot_o    ( biu_prot_o    ),
    .biu_d_o       ( biu_d_o       ),
    .biu_q_i       ( biu_q_i       ),
    .biu_ack_i     ( biu_ack_i     ),
    .biu_err_i     ( biu_err_i     )
  );

  // Response back to CPU ports
  assign mem_q_o          = rsp.q;
  assign mem_ack_o        = rsp.ack;
  assign mem_err_o        = rsp.err;
  assign mem_misaligned_o = rsp.misaligned;

endmodule

// ==== sim/dmem_tb.sv ====
`include "dmem_macros.svh"

module dmem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dmem_pkg::*;

  localparam int          WAIT_LIMIT   = 200;
  localparam int          RAND_COUNT   = 300;
  localparam logic [1:0]  PRV_M        = 2'b11;
  localparam logic [1:0]  PRV_S        = 2'b01;
  localparam logic [31:0] ERR_BASE     = 32'h0000_3000;
  localparam logic [31:0] ERR_LIMIT    = 32'h0000_3FFF;
  localparam logic [31:0] UNMAPPED_ADR = 32'h0000_9000;

  typedef enum logic [1:0] {RSP_ACK, RSP_ERR, RSP_MIS} rsp_kind_e;

  // Expected outcome of one request
  typedef struct packed {
    rsp_kind_e             kind;
    logic [`DMEM_XLEN-1:0] q;
    logic                  bus;
    logic [`DMEM_XLEN-1:0] adr;
    size_e                 size;
    logic                  we;
    logic [`DMEM_XLEN-1:0] d;
    prot_t                 prot;
  } exp_rsp_t;

  // One transfer as the BIU model saw it
  typedef struct packed {
    logic [`DMEM_XLEN-1:0] adr;
    size_e                 size;
    logic                  we;
    logic [`DMEM_XLEN-1:0] d;
    prot_t                 prot;
  } bus_obs_t;

  typedef enum logic [1:0] {BIU_IDLE, BIU_STB, BIU_DATA} biu_phase_e;

  logic                  clk_i   = 1'b0;
  logic                  rst_n_i = 1'b0;
  pma_region_t           regions [`DMEM_PMA_CNT];
  logic [1:0]            st_prv_i;
  logic                  mem_req_i;
  logic [`DMEM_XLEN-1:0] mem_adr_i;
  size_e                 mem_size_i;
  logic                  mem_we_i;
  logic [`DMEM_XLEN-1:0] mem_d_i;
  logic [`DMEM_XLEN-1:0] mem_q_o;
  logic                  mem_ack_o;
  logic                  mem_err_o;
  logic                  mem_misaligned_o;
  logic                  biu_stb_o;
  logic                  biu_stb_ack_i = 1'b0;
  logic [`DMEM_XLEN-1:0] biu_adr_o;
  size_e                 biu_size_o;
  logic                  biu_we_o;
  prot_t                 biu_prot_o;
  logic [`DMEM_XLEN-1:0] biu_d_o;
  logic [`DMEM_XLEN-1:0] biu_q_i       = '0;
  logic                  biu_ack_i     = 1'b0;
  logic                  biu_err_i     = 1'b0;

  exp_rsp_t    exp_q [$];
  bus_obs_t    bus_q [$];
  int          push_count   = 0;
  int          rsp_count    = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  bit          aborted      = 1'b0;
  logic [31:0] stim_seed    = 32'd61386;
  logic [31:0] biu_seed     = 32'd61386;
  biu_phase_e  biu_phase;
  logic [1:0]  biu_wait;
  logic [31:0] biu_cur_adr;
  bus_obs_t    seen;

  always #2 clk_i = ~clk_i;

  dmem_top uut (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .pma_regions_i    ( regions          ),
    .st_prv_i         ( st_prv_i         ),
    .mem_req_i        ( mem_req_i        ),
    .mem_adr_i        ( mem_adr_i        ),
    .mem_size_i       ( mem_size_i       ),
    .mem_we_i         ( mem_we_i         ),
    .mem_d_i          ( mem_d_i          ),
    .mem_q_o          ( mem_q_o          ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o ),
    .biu_stb_o        ( biu_stb_o        ),
    .biu_stb_ack_i    ( biu_stb_ack_i    ),
    .biu_adr_o        ( biu_adr_o        ),
    .biu_size_o       ( biu_size_o       ),
    .biu_we_o         ( biu_we_o         ),
    .biu_prot_o       ( biu_prot_o       ),
    .biu_d_o          ( biu_d_o          ),
    .biu_q_i          ( biu_q_i          ),
    .biu_ack_i        ( biu_ack_i        ),
    .biu_err_i        ( biu_err_i        )
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Read data pattern of the BIU memory
  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return (adr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic logic in_err_window(input logic [31:0] adr);
    return (adr >= ERR_BASE) && (adr <= ERR_LIMIT);
  endfunction

  // Expected response from region, permission and alignment rules
  function automatic exp_rsp_t expect_rsp(input logic [31:0] adr, input size_e size,
                                          input logic we, input logic [31:0] d,
                                          input logic [1:0] prv);
    exp_rsp_t e;
    int       hit;
    logic     mis;
    hit = -1;
    for (int i = 0; i < `DMEM_PMA_CNT; i++)
    begin
      if (hit < 0 && adr >= regions[i].base && adr <= regions[i].limit)
        hit = i;
    end
    mis = (size == SIZE_HALF && adr[0]) || (size == SIZE_WORD && adr[1:0] != 2'b00);
    e      = '0;
    e.adr  = adr;
    e.size = size;
    e.we   = we;
    e.d    = d;
    e.prot[`DMEM_PROT_DATA] = 1'b1;
    if (prv == `DMEM_PRV_U)
      e.prot[`DMEM_PROT_USER] = 1'b1;
    else
      e.prot[`DMEM_PROT_PRIV] = 1'b1;
    if (hit < 0)
      e.kind = RSP_ERR;
    else if (we ? !regions[hit].w : !regions[hit].r)
      e.kind = RSP_ERR;
    else if (mis && !regions[hit].mis_ok)
      e.kind = RSP_MIS;
    else
    begin
      e.bus  = 1'b1;
      e.kind = in_err_window(adr) ? RSP_ERR : RSP_ACK;
      e.q    = fill_word(adr);
    end
    return e;
  endfunction

  task automatic log_mismatch(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    value_errors++;
    $display("Error: %s = 0x%h, expected 0x%h (time %0t)", name, got, want, $time);
  endtask

  task automatic raise_failure(input string msg);
    other_errors++;
    $display("%s (time %0t)", msg, $time);
  endtask

  // Push one request once fewer than two are in flight
  task automatic issue(input logic [31:0] adr, input size_e size, input logic we,
                       input logic [31:0] d, input logic [1:0] prv);
    int waited;
    waited = 0;
    if (!aborted)
    begin
      @(posedge clk_i);
      while (!aborted && (push_count - rsp_count) >= `DMEM_BUF_DEPTH)
      begin
        mem_req_i <= 1'b0;
        @(posedge clk_i);
        waited++;
        if (waited > WAIT_LIMIT)
        begin
          raise_failure("Timeout waiting for a free request slot");
          aborted = 1'b1;
        end
      end
      if (!aborted)
      begin
        mem_req_i  <= 1'b1;
        mem_adr_i  <= adr;
        mem_size_i <= size;
        mem_we_i   <= we;
        mem_d_i    <= d;
        st_prv_i   <= prv;
        exp_q.push_back(expect_rsp(adr, size, we, d, prv));
        push_count++;
      end
    end
  endtask

  task automatic idle_req();
    @(posedge clk_i);
    mem_req_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!aborted && rsp_count < push_count)
    begin
      @(posedge clk_i);
      waited++;
      if (waited > WAIT_LIMIT)
      begin
        raise_failure("Timeout waiting for outstanding responses");
        aborted = 1'b1;
      end
    end
  endtask

  // Mostly back-to-back requests with a few to unmapped space
  task automatic random_traffic(input int count);
    logic [31:0] r;
    logic [31:0] base;
    logic [31:0] adr;
    size_e       size;
    for (int n = 0; n < count && !aborted; n++)
    begin
      stim_seed = lcg_next(stim_seed);
      r         = stim_seed;
      if (r[31:29] == 3'b111)
        base = UNMAPPED_ADR;
      else
        base = regions[r[28:27]].base;
      adr = base + {20'd0, r[26:15]};
      case (r[14:13])
        2'd0:    size = SIZE_BYTE;
        2'd1:    size = SIZE_HALF;
        default: size = SIZE_WORD;
      endcase
      stim_seed = lcg_next(stim_seed);
      issue(adr, size, r[12], stim_seed, r[11:10]);
      if (r[9:8] == 2'b00)
        idle_req();
    end
  endtask

  //////////////////////////////////////////////////
  // BIU model
  //////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      biu_phase     <= BIU_IDLE;
      biu_wait      <= 2'd0;
      biu_stb_ack_i <= 1'b0;
      biu_ack_i     <= 1'b0;
      biu_err_i     <= 1'b0;
    end
    else
    begin
      biu_stb_ack_i <= 1'b0;
      biu_ack_i     <= 1'b0;
      biu_err_i     <= 1'b0;
      case (biu_phase)
        BIU_IDLE:
          if (biu_stb_o)
          begin
            biu_seed = lcg_next(biu_seed);
            biu_wait  <= biu_seed[17:16];
            biu_phase <= BIU_STB;
          end
        BIU_STB:
          if (biu_wait != 2'd0)
            biu_wait <= biu_wait - 2'd1;
          else
          begin
            seen.adr  = biu_adr_o;
            seen.size = biu_size_o;
            seen.we   = biu_we_o;
            seen.d    = biu_d_o;
            seen.prot = biu_prot_o;
            bus_q.push_back(seen);
            biu_seed = lcg_next(biu_seed);
            biu_stb_ack_i <= 1'b1;
            biu_cur_adr   <= biu_adr_o;
            biu_wait      <= biu_seed[19:18];
            biu_phase     <= BIU_DATA;
          end
        default:
          if (biu_wait != 2'd0)
            biu_wait <= biu_wait - 2'd1;
          else
          begin
            if (in_err_window(biu_cur_adr))
              biu_err_i <= 1'b1;
            else
              biu_ack_i <= 1'b1;
            biu_q_i   <= fill_word(biu_cur_adr);
            biu_phase <= BIU_IDLE;
          end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Response checker
  //////////////////////////////////////////////////

  // Sampled mid-cycle since responses change on the rising edge
  always @(negedge clk_i)
  begin
    exp_rsp_t want;
    bus_obs_t obs;
    if (rst_n_i && (mem_ack_o || mem_err_o || mem_misaligned_o))
    begin
      rsp_count++;
      assert (exp_q.size() > 0)
      else raise_failure("Response pulse arrived with no request outstanding");
      if (exp_q.size() > 0)
      begin
        want = exp_q.pop_front();
        assert (mem_ack_o == (want.kind == RSP_ACK))
        else log_mismatch("mem_ack_o", 32'(mem_ack_o), 32'(want.kind == RSP_ACK));
        assert (mem_err_o == (want.kind == RSP_ERR))
        else log_mismatch("mem_err_o", 32'(mem_err_o), 32'(want.kind == RSP_ERR));
        assert (mem_misaligned_o == (want.kind == RSP_MIS))
        else log_mismatch("mem_misaligned_o", 32'(mem_misaligned_o),
                          32'(want.kind == RSP_MIS));
        if (want.kind == RSP_ACK && !want.we)
        begin
          assert (mem_q_o == want.q)
          else log_mismatch("mem_q_o", mem_q_o, want.q);
        end
        if (want.bus)
        begin
          assert (bus_q.size() > 0)
          else raise_failure("Request that should reach the BIU produced no strobe");
          if (bus_q.size() > 0)
          begin
            obs = bus_q.pop_front();
            assert (obs.adr == want.adr)
            else log_mismatch("biu_adr_o", obs.adr, want.adr);
            assert (obs.size == want.size)
            else log_mismatch("biu_size_o", 32'(obs.size), 32'(want.size));
            assert (obs.we == want.we)
            else log_mismatch("biu_we_o", 32'(obs.we), 32'(want.we));
            assert (obs.prot == want.prot)
            else log_mismatch("biu_prot_o", 32'(obs.prot), 32'(want.prot));
            if (want.we)
            begin
              assert (obs.d == want.d)
              else log_mismatch("biu_d_o", obs.d, want.d);
            end
          end
        end
        else
        begin
          // A strobe for this request would rise on the same edge as its response
          assert (!biu_stb_o && bus_q.size() == 0)
          else raise_failure("Faulting request raised biu_stb_o");
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial
  begin
    // Misaligned allowed, misaligned trapped, read-only, bus error window
    regions[0] = '{base: 32'h0000_0000, limit: 32'h0000_0FFF, r: 1'b1, w: 1'b1, mis_ok: 1'b1};
    regions[1] = '{base: 32'h0000_1000, limit: 32'h0000_1FFF, r: 1'b1, w: 1'b1, mis_ok: 1'b0};
    regions[2] = '{base: 32'h0000_2000, limit: 32'h0000_2FFF, r: 1'b1, w: 1'b0, mis_ok: 1'b0};
    regions[3] = '{base: ERR_BASE, limit: ERR_LIMIT, r: 1'b1, w: 1'b1, mis_ok: 1'b1};
    st_prv_i   = PRV_M;
    mem_req_i  = 1'b0;
    mem_adr_i  = '0;
    mem_size_i = SIZE_WORD;
    mem_we_i   = 1'b0;
    mem_d_i    = '0;

    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Plain reads and writes
    issue(32'h0000_0100, SIZE_WORD, 1'b0, 32'h0, PRV_M);
    issue(32'h0000_0104, SIZE_WORD, 1'b1, 32'hCAFE_0104, PRV_M);
    issue(32'h0000_0106, SIZE_HALF, 1'b0, 32'h0, PRV_M);
    idle_req();
    wait_drain();

    // Read-only region and unmapped space
    issue(32'h0000_2010, SIZE_WORD, 1'b1, 32'h1234_5678, PRV_M);
    issue(32'h0000_2010, SIZE_WORD, 1'b0, 32'h0, PRV_M);
    issue(32'h0001_0000, SIZE_BYTE, 1'b0, 32'h0, PRV_M);
    idle_req();
    wait_drain();

    // Misalignment trapped in region 1 and tolerated in region 0
    issue(32'h0000_1001, SIZE_HALF, 1'b0, 32'h0, PRV_M);
    issue(32'h0000_1002, SIZE_WORD, 1'b1, 32'h0BAD_1002, PRV_M);
    issue(32'h0000_0003, SIZE_HALF, 1'b0, 32'h0, PRV_M);
    issue(32'h0000_0006, SIZE_WORD, 1'b1, 32'h600D_0006, PRV_M);
    idle_req();
    wait_drain();

    // Protection code per privilege and the error window
    issue(32'h0000_0200, SIZE_WORD, 1'b0, 32'h0, `DMEM_PRV_U);
    issue(32'h0000_0204, SIZE_WORD, 1'b1, 32'hA5A5_0204, PRV_S);
    issue(32'h0000_3010, SIZE_WORD, 1'b0, 32'h0, PRV_M);
    issue(32'h0000_3020, SIZE_BYTE, 1'b1, 32'h0000_00EE, `DMEM_PRV_U);
    idle_req();
    wait_drain();

    random_traffic(RAND_COUNT);
    idle_req();
    wait_drain();

    assert (bus_q.size() == 0)
    else raise_failure("BIU transfer seen with no matching response");

    $display("Checks done: %0d requests, %0d responses, %0d value errors, %0d other errors",
             push_count, rsp_count, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0 && !aborted)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/dmem_pkg.sv
rtl/dmem_req_fifo.sv
rtl/dmem_align_chk.sv
rtl/dmem_pma_chk.sv
rtl/dmem_access_ctrl.sv
rtl/dmem_top.sv
sim/dmem_tb.sv

// ==== Makefile ====
# Verilator flow for the data memory access block

VERILATOR  ?= verilator
TOP        ?= dmem_tb
RTL_TOP    ?= dmem_top
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run did not pass, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
